/* rtl/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 64

// receive byte fifo, power of two
`define RV_RX_DEPTH 8

// store request fifo, power of two
`define RV_ST_DEPTH 4

// mmio store targets
// low byte of the store data goes out on tx
`define RV_MMIO_TX 32'h0000_0400
// low half of the store data lands on the leds
`define RV_MMIO_LED 32'h0000_0404

`endif

/* rtl/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

    // word index width of the instruction memory
    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_STORE  = 7'b0100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // loader to imem, 1 + 6 + 32 bits
    typedef struct packed {
        logic wen;
        logic [IMEM_AW-1:0] addr;
        word_t data;
    } imem_wr_t;

    // fetch/decode to execute
    typedef struct packed {
        logic valid;
        alu_op_e alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t imm;
        logic use_imm;
        logic is_store;
        logic is_jal;
        word_t pc;
    } dec_t;

    // execute to result, also the bypass
    typedef struct packed {
        logic valid;
        reg_idx_t rd;
        word_t value;
        logic is_store;
        word_t st_addr;
        word_t st_data;
    } res_t;

    // one mmio store
    typedef struct packed {
        word_t addr;
        word_t data;
    } st_req_t;

endpackage

/* rtl/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic empty,
    output logic full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // storage, no reset on the payload
    T mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // one bit wider than the pointers so full is distinct
    logic [AW:0] count;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == (AW + 1)'(DEPTH));
    // head is always visible, pop just advances
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // producer watches full, consumer watches empty
    assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("sync_fifo: push while full");
    assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("sync_fifo: pop while empty");

endmodule

/* rtl/prog_loader.sv */
`timescale 1ns/1ns

module prog_loader (
    input  logic clk,
    input  logic reset,
    input  logic prog,
    input  logic byte_valid,
    input  rv_pkg::byte_t byte_in,
    output rv_pkg::imem_wr_t imem_wr
);
    import rv_pkg::*;

    word_t shift_q;
    logic [1:0] byte_cnt;
    logic [IMEM_AW-1:0] wr_addr;
    logic prog_q;
    logic prog_fall;
    word_t word_next;

    // end of a load, next load starts at word 0
    assign prog_fall = prog_q && !prog;

    // little endian
    // newest byte enters at the top, first byte ends up in [7:0]
    assign word_next = {byte_in, shift_q[31:8]};

    always_ff @(posedge clk)
    begin
        if (byte_valid)
        begin
            shift_q <= word_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prog_q <= 1'b0;
            byte_cnt <= '0;
            wr_addr <= '0;
            imem_wr.wen <= 1'b0;
        end
        else
        begin
            prog_q <= prog;
            // write strobe lasts one cycle
            imem_wr.wen <= 1'b0;
            if (prog_fall)
            begin
                byte_cnt <= '0;
                wr_addr <= '0;
            end
            else if (byte_valid)
            begin
                byte_cnt <= byte_cnt + 2'd1;
                // fourth byte completes the word
                if (byte_cnt == 2'd3)
                begin
                    imem_wr.wen <= 1'b1;
                    imem_wr.addr <= wr_addr;
                    imem_wr.data <= word_next;
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/rv_fetch_decode.sv */
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_fetch_decode (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic stall,
    input  logic redirect,
    input  rv_pkg::word_t redirect_pc,
    input  rv_pkg::imem_wr_t imem_wr,
    output rv_pkg::dec_t dec
);
    import rv_pkg::*;

    word_t imem [`RV_IMEM_WORDS];
    word_t pc;
    word_t pc_q;
    word_t instr_q;
    logic fetch_valid_q;

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_j;

    ////////////////////////////////////////////////////////////
    // imem and pc

    always_ff @(posedge clk)
    begin
        if (imem_wr.wen)
        begin
            imem[imem_wr.addr] <= imem_wr.data;
        end
    end

    // synchronous read, instr_q lags pc by one cycle
    always_ff @(posedge clk)
    begin
        if (reset || !run)
        begin
            pc <= '0;
            fetch_valid_q <= 1'b0;
        end
        else if (!stall)
        begin
            if (redirect)
            begin
                // jal, drop the word behind it
                pc <= redirect_pc;
                fetch_valid_q <= 1'b0;
            end
            else
            begin
                pc <= pc + 32'd4;
                pc_q <= pc;
                instr_q <= imem[pc[IMEM_AW+1:2]];
                fetch_valid_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // decode

    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    always_comb
    begin
        dec = '0;
        dec.pc = pc_q;
        dec.rd = instr_q[11:7];
        dec.rs1 = instr_q[19:15];
        dec.rs2 = instr_q[24:20];
        dec.alu_op = ALU_ADD;
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        case (opcode)
            OPC_LUI:
            begin
                dec.valid = 1'b1;
                dec.alu_op = ALU_PASS_B;
                dec.imm = imm_u;
            end
            OPC_OP_IMM:
            begin
                dec.valid = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = ALU_ADD;
                    3'b111: dec.alu_op = ALU_AND;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b100: dec.alu_op = ALU_XOR;
                    // shifts and compares not supported
                    default: dec.valid = 1'b0;
                endcase
            end
            OPC_OP:
            begin
                dec.valid = 1'b1;
                dec.use_imm = 1'b0;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = ALU_ADD;
                    10'b0100000_000: dec.alu_op = ALU_SUB;
                    10'b0000000_111: dec.alu_op = ALU_AND;
                    10'b0000000_110: dec.alu_op = ALU_OR;
                    10'b0000000_100: dec.alu_op = ALU_XOR;
                    default: dec.valid = 1'b0;
                endcase
            end
            OPC_STORE:
            begin
                // sw only, no destination
                dec.valid = (funct3 == 3'b010);
                dec.is_store = 1'b1;
                dec.imm = imm_s;
                dec.rd = '0;
            end
            OPC_JAL:
            begin
                dec.valid = 1'b1;
                dec.is_jal = 1'b1;
                dec.imm = imm_j;
            end
            // anything else is a bubble
            default: dec.valid = 1'b0;
        endcase
        dec.valid = dec.valid && fetch_valid_q;
    end

    // loader owns imem only while the core is held
    assert property (@(posedge clk) disable iff (reset) imem_wr.wen |-> !run)
        else $error("rv_fetch_decode: imem write while running");

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  rv_pkg::dec_t dec,
    input  rv_pkg::word_t rs1_val,
    input  rv_pkg::word_t rs2_val,
    input  rv_pkg::res_t byp,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output logic redirect,
    output rv_pkg::word_t redirect_pc,
    output rv_pkg::res_t res
);
    import rv_pkg::*;

    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_out;
    word_t link;
    res_t res_next;

    // a result that will land in the indexed register
    function automatic logic hit(input res_t r, input reg_idx_t idx);
        return r.valid && !r.is_store && (r.rd != '0) && (r.rd == idx);
    endfunction

    // register reads go to the file in rv_result
    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    ////////////////////////////////////////////////////////////
    // operands, youngest producer wins

    assign op_a = hit(res, dec.rs1) ? res.value :
                  hit(byp, dec.rs1) ? byp.value : rs1_val;
    assign rs2_fwd = hit(res, dec.rs2) ? res.value :
                     hit(byp, dec.rs2) ? byp.value : rs2_val;
    assign op_b = dec.use_imm ? dec.imm : rs2_fwd;

    always_comb
    begin
        case (dec.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR: alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            // lui
            default: alu_out = op_b;
        endcase
    end

    // jal, link is pc + 4, target is pc relative
    assign link = dec.pc + 32'd4;
    assign redirect = dec.valid && dec.is_jal && !stall;
    assign redirect_pc = dec.pc + dec.imm;

    always_comb
    begin
        res_next.valid = dec.valid;
        res_next.rd = dec.rd;
        res_next.value = dec.is_jal ? link : alu_out;
        res_next.is_store = dec.is_store;
        // sw address is rs1 + imm through the adder
        res_next.st_addr = alu_out;
        res_next.st_data = rs2_fwd;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            res.valid <= 1'b0;
        else if (!stall)
            res <= res_next;
    end

endmodule

/* rtl/rv_result.sv */
`timescale 1ns/1ns

module rv_result (
    input  logic clk,
    input  logic reset,
    input  logic stall_in,
    input  rv_pkg::res_t res_in,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t rs1_val,
    output rv_pkg::word_t rs2_val,
    output rv_pkg::res_t byp,
    output logic st_push,
    output rv_pkg::st_req_t st_req,
    input  logic st_full,
    output logic stall
);
    import rv_pkg::*;

    word_t rf [32];
    res_t wb_q;
    logic rf_we;
    logic st_hold;

    // result stage register, held while frozen
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_q.valid <= 1'b0;
        else if (!stall_in)
            wb_q <= res_in;
    end

    // stores carry no destination, x0 is never a target
    assign rf_we = wb_q.valid && !wb_q.is_store && (wb_q.rd != '0);

    // x0 cleared once, the write port never reaches it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rf[0] <= '0;
        end
        else if (rf_we)
        begin
            rf[wb_q.rd] <= wb_q.value;
        end
    end

    // reads see this cycle's write
    assign rs1_val = (rf_we && wb_q.rd == rs1) ? wb_q.value : rf[rs1];
    assign rs2_val = (rf_we && wb_q.rd == rs2) ? wb_q.value : rf[rs2];

    assign byp = wb_q;

    // store issue, freeze everything while the fifo is full
    assign st_hold = wb_q.valid && wb_q.is_store;
    assign st_push = st_hold && !st_full;
    assign stall = st_hold && st_full;
    assign st_req.addr = wb_q.st_addr;
    assign st_req.data = wb_q.st_data;

    // x0 reads zero through the file, so no write ever landed on it
    assert property (@(posedge clk) disable iff (reset)
        ((rs1 == '0) |-> (rs1_val == '0)) and ((rs2 == '0) |-> (rs2_val == '0)))
        else $error("rv_result: x0 read nonzero");

endmodule

/* rtl/rv_uart_top.sv */
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_uart_top (
    input  logic clk,
    input  logic reset,
    input  logic prog,
    input  logic rx_pres,
    input  rv_pkg::byte_t rx_dout,
    output logic rx_fifo_full,
    input  logic tx_ready,
    output logic tx_wen,
    output rv_pkg::byte_t tx_dout,
    output logic [15:0] led
);
    import rv_pkg::*;

    byte_t rx_byte;
    logic rx_empty;
    logic rx_pop;
    imem_wr_t imem_wr;
    logic loaded;
    logic run;
    dec_t dec;
    res_t res;
    res_t byp;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t rs1_val;
    word_t rs2_val;
    logic redirect;
    word_t redirect_pc;
    logic stall;
    logic st_push;
    logic st_full;
    logic st_empty;
    logic st_pop;
    st_req_t st_req;
    st_req_t st_head;
    logic head_is_tx;
    logic head_is_led;

    ////////////////////////////////////////////////////////////
    // receive and load

    sync_fifo #(.T(byte_t), .DEPTH(`RV_RX_DEPTH)) u_rx_fifo (
        .clk(clk), .reset(reset), .push(rx_pres), .din(rx_dout),
        .pop(rx_pop), .dout(rx_byte), .empty(rx_empty), .full(rx_fifo_full)
    );

    // bytes wait in the fifo until prog is raised
    assign rx_pop = prog && !rx_empty;

    prog_loader u_loader (
        .clk(clk), .reset(reset), .prog(prog), .byte_valid(rx_pop),
        .byte_in(rx_byte), .imem_wr(imem_wr)
    );

    // core idles after reset until a program has been loaded
    always_ff @(posedge clk)
    begin
        if (reset)
            loaded <= 1'b0;
        else if (prog)
            loaded <= 1'b1;
    end
    assign run = loaded && !prog;

    ////////////////////////////////////////////////////////////
    // core

    rv_fetch_decode u_fd (
        .clk(clk), .reset(reset), .run(run), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .imem_wr(imem_wr), .dec(dec)
    );

    rv_execute u_ex (
        .clk(clk), .reset(reset), .stall(stall), .dec(dec), .rs1_val(rs1_val),
        .rs2_val(rs2_val), .byp(byp), .rs1(rs1), .rs2(rs2), .redirect(redirect),
        .redirect_pc(redirect_pc), .res(res)
    );

    rv_result u_res (
        .clk(clk), .reset(reset), .stall_in(stall), .res_in(res), .rs1(rs1),
        .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val), .byp(byp),
        .st_push(st_push), .st_req(st_req), .st_full(st_full), .stall(stall)
    );

    ////////////////////////////////////////////////////////////
    // mmio drain

    sync_fifo #(.T(st_req_t), .DEPTH(`RV_ST_DEPTH)) u_st_fifo (
        .clk(clk), .reset(reset), .push(st_push), .din(st_req),
        .pop(st_pop), .dout(st_head), .empty(st_empty), .full(st_full)
    );

    assign head_is_tx = (st_head.addr == `RV_MMIO_TX);
    assign head_is_led = (st_head.addr == `RV_MMIO_LED);

    // only tx waits on ready, unmapped stores are dropped
    assign st_pop = !st_empty && (!head_is_tx || tx_ready);
    assign tx_wen = st_pop && head_is_tx;
    assign tx_dout = st_head.data[7:0];

    always_ff @(posedge clk)
    begin
        if (reset)
            led <= '0;
        else if (st_pop && head_is_led)
            led <= st_head.data[15:0];
    end

endmodule

/* sim/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

////////////////////////////////////////////////////////////
// rv32i encoders

function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t enc_i(input logic [2:0] f3, input reg_idx_t rd,
                                input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

// sw only
function automatic word_t enc_s(input reg_idx_t rs1, input reg_idx_t rs2,
                                input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_u(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

// byte offset, bit 0 dropped by the format
function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

////////////////////////////////////////////////////////////
// program builder with its own model of the isa

// appends one program to img, expected bytes to exp_tx, leds to led_val
task automatic build_program(input int sec, input int n_ops);
    int first;
    int k;
    int n_tx;
    int op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    logic [11:0] imm;
    logic [19:0] upper;
    word_t bi;
    word_t r;
    word_t w;
    word_t link;
    first = img.size();
    n_tx = exp_tx.size();
    // x8 holds the mmio base for the whole program
    img.push_back(enc_i(3'b000, 5'd8, 5'd0, 12'(`RV_MMIO_TX)));
    mreg[8] = `RV_MMIO_TX;
    // x1..x4 from lui and a dependent addi
    for (k = 1; k <= 4; k++)
    begin
        upper = 20'(take_bits(20));
        imm = 12'(take_bits(12));
        img.push_back(enc_u(reg_idx_t'(k), upper));
        img.push_back(enc_i(3'b000, reg_idx_t'(k), reg_idx_t'(k), imm));
        mreg[k] = {upper, 12'b0} + {{20{imm[11]}}, imm};
    end
    // only x1..x4, so most sources are still in flight
    for (k = 0; k < n_ops; k++)
    begin
        op = int'(take_bits(4) % 10);
        rd = reg_idx_t'(take_bits(2)) + 5'd1;
        ra = reg_idx_t'(take_bits(2)) + 5'd1;
        rb = reg_idx_t'(take_bits(2)) + 5'd1;
        upper = 20'(take_bits(20));
        imm = 12'(take_bits(12));
        bi = {{20{imm[11]}}, imm};
        case (op)
            0: r = mreg[ra] + mreg[rb];
            1: r = mreg[ra] - mreg[rb];
            2: r = mreg[ra] & mreg[rb];
            3: r = mreg[ra] | mreg[rb];
            4: r = mreg[ra] ^ mreg[rb];
            5: r = mreg[ra] + bi;
            6: r = mreg[ra] & bi;
            7: r = mreg[ra] | bi;
            8: r = mreg[ra] ^ bi;
            default: r = {upper, 12'b0};
        endcase
        case (op)
            0: w = enc_r(7'h00, 3'b000, rd, ra, rb);
            1: w = enc_r(7'h20, 3'b000, rd, ra, rb);
            2: w = enc_r(7'h00, 3'b111, rd, ra, rb);
            3: w = enc_r(7'h00, 3'b110, rd, ra, rb);
            4: w = enc_r(7'h00, 3'b100, rd, ra, rb);
            5: w = enc_i(3'b000, rd, ra, imm);
            6: w = enc_i(3'b111, rd, ra, imm);
            7: w = enc_i(3'b110, rd, ra, imm);
            8: w = enc_i(3'b100, rd, ra, imm);
            default: w = enc_u(rd, upper);
        endcase
        img.push_back(w);
        mreg[rd] = r;
        // store right behind its producer
        if (take_bits(1) != 0)
        begin
            img.push_back(enc_s(5'd8, rd, 12'd0));
            exp_tx.push_back(r[7:0]);
        end
    end
    // low half of the last result to the leds
    img.push_back(enc_s(5'd8, rd, 12'(`RV_MMIO_LED - `RV_MMIO_TX)));
    led_val[sec] = r[15:0];
    // jal over a poison store of x0, then send the link byte
    link = word_t'(4 * (img.size() - first + 1));
    img.push_back(enc_j(5'd5, 21'd8));
    img.push_back(enc_s(5'd8, 5'd0, 12'd0));
    img.push_back(enc_s(5'd8, 5'd5, 12'd0));
    mreg[5] = link;
    exp_tx.push_back(link[7:0]);
    // park on a self loop
    img.push_back(enc_j(5'd0, 21'd0));
    prog_first[sec] = first;
    prog_len[sec] = img.size() - first;
    tx_count[sec] = exp_tx.size() - n_tx;
endtask

`endif

/* sim/tb_rvtop.sv */
`timescale 1ns/1ns
`include "rv_config.svh"

module tb_rvtop;
    import rv_pkg::*;

    logic clk;
    logic reset;
    logic prog;
    logic rx_pres;
    byte_t rx_dout;
    logic rx_fifo_full;
    logic tx_ready = 1'b1;
    logic tx_wen;
    byte_t tx_dout;
    logic [15:0] led;

    // stimulus and model state
    logic [31:0] lfsr;
    word_t img [$];
    byte_t exp_tx [$];
    word_t mreg [32];
    int prog_first [2];
    int prog_len [2];
    int tx_count [2];
    logic [15:0] led_val [2];
    logic [15:0] led_target;
    logic ready_random;
    int ready_span;
    int total_words = 0;
    int k;

    rv_uart_top u_dut (
        .clk(clk), .reset(reset), .prog(prog), .rx_pres(rx_pres), .rx_dout(rx_dout),
        .rx_fifo_full(rx_fifo_full), .tx_ready(tx_ready), .tx_wen(tx_wen),
        .tx_dout(tx_dout), .led(led)
    );

    // 4 ns period
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic fb;
        int i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("Error: %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    `include "tb_programs.svh"

    // bytes little endian, one per cycle while prog is high
    task automatic load_program(input int sec);
        int i;
        int b;
        word_t w;
        @(negedge clk);
        prog = 1'b1;
        for (i = 0; i < prog_len[sec]; i++)
        begin
            w = img[prog_first[sec] + i];
            for (b = 0; b < 4; b++)
            begin
                @(negedge clk);
                rx_pres = 1'b1;
                rx_dout = w[8*b +: 8];
            end
        end
        @(negedge clk);
        rx_pres = 1'b0;
        // last byte spends a cycle in the fifo, one in the loader
        repeat (3) @(negedge clk);
        prog = 1'b0;
    endtask

    task automatic wait_tx_left(input int n);
        while (exp_tx.size() > n)
            @(negedge clk);
    endtask

    // tx_ready in random spans of one level
    always @(negedge clk)
    begin
        if (!ready_random)
            tx_ready = 1'b1;
        else if (ready_span == 0)
        begin
            tx_ready = (take_bits(1) != 0);
            ready_span = int'(take_bits(3)) + 1;
        end
        else
            ready_span = ready_span - 1;
    end

    ////////////////////////////////////////////////////////////
    // checks

    // each tx byte must be the head of the model queue
    always @(posedge clk)
    begin
        if (!reset && tx_wen)
        begin
            assert (exp_tx.size() != 0 && tx_dout == exp_tx[0])
                exp_tx.delete(0);
            else
                fail_run($sformatf("tx byte %h, expected %h with %0d pending", tx_dout,
                                   (exp_tx.size() != 0) ? exp_tx[0] : 8'h00, exp_tx.size()));
        end
    end

    assert property (@(posedge clk) disable iff (reset) tx_wen |-> tx_ready)
        else fail_run("tx_wen pulsed while tx_ready was low");

    // leds only move to what the running program stores
    assert property (@(posedge clk) disable iff (reset) (led != $past(led)) |-> (led == led_target))
        else fail_run($sformatf("led %h, expected %h", led, led_target));

    ////////////////////////////////////////////////////////////
    // sequence

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        prog = 1'b0;
        rx_pres = 1'b0;
        rx_dout = '0;
        lfsr = 32'd90489;
        ready_random = 1'b0;
        ready_span = 0;
        led_target = '0;
        build_program(0, 16);
        build_program(1, 12);
        total_words = img.size();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        assert (!tx_wen && led == '0 && !rx_fifo_full)
        else
            fail_run($sformatf("after reset tx_wen %b, led %h, rx_fifo_full %b",
                               tx_wen, led, rx_fifo_full));
        // first program, receiver always ready
        led_target = led_val[0];
        load_program(0);
        wait_tx_left(tx_count[1]);
        assert (led == led_val[0])
        else
            fail_run($sformatf("led %h, expected %h", led, led_val[0]));
        // second program under back-pressure, switched away from the negedge
        @(posedge clk);
        ready_random = 1'b1;
        led_target = led_val[1];
        load_program(1);
        wait_tx_left(0);
        // self loop stays quiet, any byte now trips the queue check
        repeat (50) @(negedge clk);
        // core keeps looping and the receive fifo just fills
        for (k = 0; k < `RV_RX_DEPTH; k++)
        begin
            assert (!rx_fifo_full)
            else
                fail_run($sformatf("rx_fifo_full high after only %0d bytes", k));
            rx_pres = 1'b1;
            rx_dout = byte_t'(k);
            @(negedge clk);
        end
        rx_pres = 1'b0;
        assert (rx_fifo_full)
        else
            fail_run("rx_fifo_full stayed low with the receive fifo at its depth");
        repeat (4) @(negedge clk);
        if (exp_tx.size() == 0 && led == led_val[1])
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
            fail_run("tx bytes still pending or wrong led at the end of the run");
    end

    // 200 cycles per loaded word plus slack
    initial
    begin
        wait (total_words > 0);
        repeat (200 * total_words + 2000) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

/* build.f */
+incdir+rtl
+incdir+sim
rtl/rv_pkg.sv
rtl/sync_fifo.sv
rtl/prog_loader.sv
rtl/rv_fetch_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_uart_top.sv
sim/tb_rvtop.sv

/* Makefile */
# Verilator flow for the rv_uart_top testbench
# override any variable on the command line, e.g. make sim SEED=7

VERILATOR ?= verilator
TOP ?= tb_rvtop
SEED ?= 1
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
SOURCES := $(wildcard rtl/*.sv rtl/*.svh sim/*.sv sim/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits nonzero on $$fatal, which fails this target
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+rand+reset+2

clean:
	rm -rf $(OBJ_DIR)
